// ==== rtl/pc_io_pkg.sv ====
package pc_io_pkg;

    // ########################################
    // cpu i/o port map
    // ########################################

    localparam logic [15:0] port_kbd_data   = 16'h0060; // keyboard data byte.
    localparam logic [15:0] port_kbd_status = 16'h0064; // keyboard status with bit 0 as byte ready.
    localparam logic [15:0] port_crtc_index = 16'h03D4; // crtc register select.
    localparam logic [15:0] port_crtc_data  = 16'h03D5; // crtc selected register data.

    // ########################################
    // crtc registers
    // ########################################

    localparam logic [3:0] crtc_cursor_hi = 4'hE; // cursor position bits 10..8.
    localparam logic [3:0] crtc_cursor_lo = 4'hF; // cursor position bits 7..0.

    localparam int cursor_width = 11;             // text cursor address width.

    // ########################################
    // keyboard
    // ########################################

    localparam logic [7:0] at_break_prefix = 8'hF0; // set-2 key release prefix.

    localparam int ps2_frame_bits  = 11;   // start, 8 data, parity, stop.
    localparam int ps2_idle_cycles = 2000; // clock50 cycles without a ps2 clock fall.

    // counter widths.
    localparam int ps2_cnt_width  = $clog2(ps2_frame_bits);
    localparam int ps2_idle_width = $clog2(ps2_idle_cycles + 1);

endpackage

// ==== rtl/ps2_receiver.sv ====
`timescale 1ns/10ps

module ps2_receiver
    import pc_io_pkg::*;
(
    input  logic       clock50,
    input  logic       arst_n,
    input  logic       ps2_clk,
    input  logic       ps2_dat,
    output logic [7:0] rx_byte,
    output logic       rx_valid
);

    logic                          clk_meta;  // first synchronizer stage.
    logic                          clk_sync;  // second synchronizer stage.
    logic                          clk_prev;  // delayed copy for the fall detect.
    logic                          dat_meta;
    logic                          dat_sync;
    logic                          clk_fall;  // one cycle per ps2 clock fall.
    logic [ps2_cnt_width-1:0]      bit_cnt;   // bits taken in the current frame.
    logic                          last_bit;  // the stop bit is on the line.
    logic [ps2_idle_width-1:0]     idle_cnt;  // cycles since the last fall.
    logic                          idle_hit;
    logic [ps2_frame_bits-2:0]     shift_reg; // bits taken so far, lsb first.
    logic [ps2_frame_bits-1:0]     frame_next;
    logic                          frame_ok;

    // ########################################
    // pin sync and edge detect
    // ########################################

    always_ff @(posedge clock50 or negedge arst_n) begin
        if (!arst_n) begin
            clk_meta <= 1'b1;                  // ps2 lines idle high.
            clk_sync <= 1'b1;
            clk_prev <= 1'b1;
            dat_meta <= 1'b1;
            dat_sync <= 1'b1;
        end else begin
            clk_meta <= ps2_clk;
            clk_sync <= clk_meta;
            clk_prev <= clk_sync;
            dat_meta <= ps2_dat;
            dat_sync <= dat_meta;
        end
    end

    assign clk_fall = clk_prev & ~clk_sync;

    // ########################################
    // frame assembly
    // ########################################

    assign last_bit   = (bit_cnt == ps2_cnt_width'(ps2_frame_bits - 1));
    assign idle_hit   = (idle_cnt == ps2_idle_width'(ps2_idle_cycles));
    assign frame_next = {dat_sync, shift_reg};  // newest bit enters at the top.

    // start low, stop high, odd parity over data and parity bit.
    assign frame_ok = ~frame_next[0] & frame_next[ps2_frame_bits-1] & (^frame_next[9:1]);

    always_ff @(posedge clock50 or negedge arst_n) begin
        if (!arst_n) begin
            bit_cnt  <= '0;
            idle_cnt <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= 1'b0;                  // single cycle pulse.
            if (clk_fall) begin
                idle_cnt <= '0;
                if (last_bit) begin
                    bit_cnt  <= '0;
                    rx_valid <= frame_ok;      // bad frames vanish here.
                end else begin
                    bit_cnt <= bit_cnt + 1'b1;
                end
            end else if (idle_hit) begin
                bit_cnt <= '0;                 // a quiet line drops the partial frame.
            end else begin
                idle_cnt <= idle_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clock50) begin
        if (clk_fall) begin
            shift_reg <= frame_next[ps2_frame_bits-1:1];
        end
        if (clk_fall && last_bit) begin
            rx_byte <= frame_next[8:1];        // data bits only.
        end
    end

endmodule

// ==== rtl/scancode_xlat.sv ====
`timescale 1ns/10ps

module scancode_xlat
    import pc_io_pkg::*;
(
    input  logic       clock50,
    input  logic       arst_n,
    input  logic [7:0] rx_byte,
    input  logic       rx_valid,
    output logic [7:0] key_code,
    output logic       key_valid
);

    logic [7:0] xt_code;       // set-1 equivalent of rx_byte.
    logic       break_pending; // last byte was the release prefix.

    // ########################################
    // set-2 to set-1 table
    // ########################################

    always_comb begin
        case (rx_byte)
            8'h1C: xt_code = 8'h1E; // a.
            8'h32: xt_code = 8'h30; // b.
            8'h21: xt_code = 8'h2E; // c.
            8'h23: xt_code = 8'h20; // d.
            8'h24: xt_code = 8'h12; // e.
            8'h2B: xt_code = 8'h21; // f.
            8'h34: xt_code = 8'h22; // g.
            8'h33: xt_code = 8'h23; // h.
            8'h43: xt_code = 8'h17; // i.
            8'h3B: xt_code = 8'h24; // j.
            8'h42: xt_code = 8'h25; // k.
            8'h4B: xt_code = 8'h26; // l.
            8'h3A: xt_code = 8'h32; // m.
            8'h31: xt_code = 8'h31; // n.
            8'h44: xt_code = 8'h18; // o.
            8'h4D: xt_code = 8'h19; // p.
            8'h15: xt_code = 8'h10; // q.
            8'h2D: xt_code = 8'h13; // r.
            8'h1B: xt_code = 8'h1F; // s.
            8'h2C: xt_code = 8'h14; // t.
            8'h3C: xt_code = 8'h16; // u.
            8'h2A: xt_code = 8'h2F; // v.
            8'h1D: xt_code = 8'h11; // w.
            8'h22: xt_code = 8'h2D; // x.
            8'h35: xt_code = 8'h15; // y.
            8'h1A: xt_code = 8'h2C; // z.
            8'h45: xt_code = 8'h0B; // 0.
            8'h16: xt_code = 8'h02; // 1.
            8'h1E: xt_code = 8'h03; // 2.
            8'h26: xt_code = 8'h04; // 3.
            8'h25: xt_code = 8'h05; // 4.
            8'h2E: xt_code = 8'h06; // 5.
            8'h36: xt_code = 8'h07; // 6.
            8'h3D: xt_code = 8'h08; // 7.
            8'h3E: xt_code = 8'h09; // 8.
            8'h46: xt_code = 8'h0A; // 9.
            8'h0E: xt_code = 8'h29; // backtick.
            8'h4E: xt_code = 8'h0C; // minus.
            8'h55: xt_code = 8'h0D; // equals.
            8'h5D: xt_code = 8'h2B; // backslash.
            8'h54: xt_code = 8'h1A; // open bracket.
            8'h5B: xt_code = 8'h1B; // close bracket.
            8'h4C: xt_code = 8'h27; // semicolon.
            8'h52: xt_code = 8'h28; // quote.
            8'h41: xt_code = 8'h33; // comma.
            8'h49: xt_code = 8'h34; // period.
            8'h4A: xt_code = 8'h35; // slash.
            8'h66: xt_code = 8'h0E; // backspace.
            8'h29: xt_code = 8'h39; // space.
            8'h0D: xt_code = 8'h0F; // tab.
            // modifiers
            8'h58: xt_code = 8'h3A; // caps lock.
            8'h12: xt_code = 8'h2A; // left shift.
            8'h14: xt_code = 8'h1D; // left ctrl.
            8'h11: xt_code = 8'h38; // left alt.
            8'h1F: xt_code = 8'h5B; // left win.
            8'h59: xt_code = 8'h36; // right shift.
            8'h27: xt_code = 8'h5C; // right win.
            8'h2F: xt_code = 8'h5D; // menu.
            8'h5A: xt_code = 8'h1C; // enter.
            // function row
            8'h76: xt_code = 8'h01; // esc.
            8'h05: xt_code = 8'h3B; // f1.
            8'h06: xt_code = 8'h3C; // f2.
            8'h04: xt_code = 8'h3D; // f3.
            8'h0C: xt_code = 8'h3E; // f4.
            8'h03: xt_code = 8'h3F; // f5.
            8'h0B: xt_code = 8'h40; // f6.
            8'h83: xt_code = 8'h41; // f7 is the one code above 7fh.
            8'h0A: xt_code = 8'h42; // f8.
            8'h01: xt_code = 8'h43; // f9.
            8'h09: xt_code = 8'h44; // f10.
            8'h78: xt_code = 8'h57; // f11.
            8'h07: xt_code = 8'h58; // f12.
            8'h7E: xt_code = 8'h46; // scroll lock.
            // keypad
            8'h77: xt_code = 8'h45; // num lock.
            8'h7C: xt_code = 8'h37; // keypad star.
            8'h7B: xt_code = 8'h4A; // keypad minus.
            8'h79: xt_code = 8'h4E; // keypad plus.
            8'h71: xt_code = 8'h53; // keypad dot.
            8'h70: xt_code = 8'h52; // keypad 0.
            8'h69: xt_code = 8'h4F; // keypad 1.
            8'h72: xt_code = 8'h50; // keypad 2.
            8'h7A: xt_code = 8'h51; // keypad 3.
            8'h6B: xt_code = 8'h4B; // keypad 4.
            8'h73: xt_code = 8'h4C; // keypad 5.
            8'h74: xt_code = 8'h4D; // keypad 6.
            8'h6C: xt_code = 8'h47; // keypad 7.
            8'h75: xt_code = 8'h48; // keypad 8.
            8'h7D: xt_code = 8'h49; // keypad 9.
            default: xt_code = rx_byte; // e0, e1 and unknown codes go through as is.
        endcase
    end

    // ########################################
    // break prefix tracking
    // ########################################

    always_ff @(posedge clock50 or negedge arst_n) begin
        if (!arst_n) begin
            break_pending <= 1'b0;
            key_valid     <= 1'b0;
        end else begin
            key_valid <= 1'b0;
            if (rx_valid) begin
                if (rx_byte == at_break_prefix) begin
                    break_pending <= 1'b1;     // prefix itself is not delivered.
                end else begin
                    break_pending <= 1'b0;
                    key_valid     <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clock50) begin
        if (rx_valid && rx_byte != at_break_prefix) begin
            key_code <= break_pending ? {1'b1, xt_code[6:0]} : xt_code; // release sets bit 7.
        end
    end

endmodule

// ==== rtl/keyboard_port.sv ====
`timescale 1ns/10ps

module keyboard_port
    import pc_io_pkg::*;
(
    input  logic        clock50,
    input  logic        arst_n,
    input  logic [7:0]  key_code,
    input  logic        key_valid,
    input  logic        read_done,
    input  logic [15:0] port_addr,
    output logic [7:0]  kbd_data
);

    logic [7:0] held_byte; // last translated byte, read or not.
    logic       kbd_ready; // status bit 0.

    // ########################################
    // byte holder
    // ########################################

    always_ff @(posedge clock50) begin
        if (key_valid) begin
            held_byte <= key_code;             // newest byte wins on overrun.
        end
    end

    // ########################################
    // ready flag and read latch
    // ########################################

    always_ff @(posedge clock50 or negedge arst_n) begin
        if (!arst_n) begin
            kbd_ready <= 1'b0;
            kbd_data  <= '0;
        end else begin
            if (read_done) begin
                case (port_addr)
                    port_kbd_data: begin
                        kbd_data  <= held_byte; // cpu takes the byte.
                        kbd_ready <= 1'b0;      // and acknowledges it.
                    end
                    port_kbd_status: begin
                        kbd_data <= {7'h00, kbd_ready};
                    end
                    default: begin
                        kbd_data <= kbd_data;   // not ours.
                    end
                endcase
            end
            // a byte arriving with the read keeps ready up,
            // so the new byte is never lost behind the acknowledge.
            if (key_valid) begin
                kbd_ready <= 1'b1;
            end
        end
    end

endmodule

// ==== rtl/crtc_regs.sv ====
`timescale 1ns/10ps

module crtc_regs
    import pc_io_pkg::*;
(
    input  logic                    clock50,
    input  logic                    arst_n,
    input  logic                    write_done,
    input  logic [15:0]             port_addr,
    input  logic [15:0]             port_out,
    output logic [cursor_width-1:0] cursor
);

    logic [3:0] crtc_index; // register picked by the last 3d4h write.

    // ########################################
    // index and cursor registers
    // ########################################

    always_ff @(posedge clock50 or negedge arst_n) begin
        if (!arst_n) begin
            crtc_index <= '0;
            cursor     <= '0;
        end else if (write_done) begin
            case (port_addr)
                port_crtc_index: begin
                    crtc_index <= port_out[3:0];          // low nibble only.
                end
                port_crtc_data: begin
                    case (crtc_index)
                        crtc_cursor_hi: begin
                            cursor[cursor_width-1:8] <= port_out[cursor_width-9:0]; // top bits.
                        end
                        crtc_cursor_lo: begin
                            cursor[7:0] <= port_out[7:0]; // low byte.
                        end
                        default: begin
                            cursor <= cursor;             // other registers not kept.
                        end
                    endcase
                end
                default: begin
                    crtc_index <= crtc_index;             // other ports ignored.
                end
            endcase
        end
    end

endmodule

// ==== rtl/port_controller.sv ====
`timescale 1ns/10ps

module port_controller
    import pc_io_pkg::*;
(
    input  logic                    clock50,
    input  logic                    arst_n,
    input  logic [15:0]             port_addr,
    input  logic [15:0]             port_out,
    input  logic                    port_clk,
    input  logic                    port_read,
    input  logic                    ps2_clk,
    input  logic                    ps2_dat,
    output logic [15:0]             port_in,
    output logic [cursor_width-1:0] cursor
);

    logic       read_prev;  // port_read one clock back.
    logic       clk_prev;   // port_clk one clock back.
    logic       read_done;  // cpu read finished.
    logic       write_done; // cpu write finished.
    logic [7:0] rx_byte;
    logic       rx_valid;
    logic [7:0] key_code;
    logic       key_valid;
    logic [7:0] kbd_data;

    // ########################################
    // strobe falling edges
    // ########################################

    always_ff @(posedge clock50 or negedge arst_n) begin
        if (!arst_n) begin
            read_prev  <= 1'b0;
            clk_prev   <= 1'b0;
            read_done  <= 1'b0;
            write_done <= 1'b0;
        end else begin
            read_prev  <= port_read;
            clk_prev   <= port_clk;
            read_done  <= read_prev & ~port_read; // high to low seen this edge.
            write_done <= clk_prev & ~port_clk;
        end
    end

    // ########################################
    // read data mux
    // ########################################

    always_comb begin
        case (port_addr)
            port_kbd_data, port_kbd_status: port_in = {8'h00, kbd_data};
            default:                        port_in = '0;
        endcase
    end

    ps2_receiver u_ps2_receiver (
        .clock50  (clock50),
        .arst_n   (arst_n),
        .ps2_clk  (ps2_clk),
        .ps2_dat  (ps2_dat),
        .rx_byte  (rx_byte),
        .rx_valid (rx_valid)
    );

    scancode_xlat u_scancode_xlat (
        .clock50   (clock50),
        .arst_n    (arst_n),
        .rx_byte   (rx_byte),
        .rx_valid  (rx_valid),
        .key_code  (key_code),
        .key_valid (key_valid)
    );

    keyboard_port u_keyboard_port (
        .clock50   (clock50),
        .arst_n    (arst_n),
        .key_code  (key_code),
        .key_valid (key_valid),
        .read_done (read_done),
        .port_addr (port_addr),
        .kbd_data  (kbd_data)
    );

    crtc_regs u_crtc_regs (
        .clock50    (clock50),
        .arst_n     (arst_n),
        .write_done (write_done),
        .port_addr  (port_addr),
        .port_out   (port_out),
        .cursor     (cursor)
    );

endmodule

// ==== testbench/tb_port_controller.sv ====
`timescale 1ns/10ps

module tb_port_controller
    import pc_io_pkg::*;
();

    logic                    clock50 = 1'b0;
    logic                    arst_n;
    logic [15:0]             port_addr;
    logic [15:0]             port_out;
    logic                    port_clk;
    logic                    port_read;
    logic                    ps2_clk;
    logic                    ps2_dat;
    logic [15:0]             port_in;
    logic [cursor_width-1:0] cursor;

    logic [31:0] lfsr = 32'h5d6f; // random source with a fixed seed.
    logic [7:0]  at_codes [0:5];  // set-2 make codes sent by the keyboard.
    logic [7:0]  xt_codes [0:5];  // set-1 codes the cpu should read.
    int          order    [0:5];  // shuffled key order.

    always #2 clock50 = ~clock50; // 4 ns period.

    port_controller DUT (
        .clock50   (clock50),
        .arst_n    (arst_n),
        .port_addr (port_addr),
        .port_out  (port_out),
        .port_clk  (port_clk),
        .port_read (port_read),
        .ps2_clk   (ps2_clk),
        .ps2_dat   (ps2_dat),
        .port_in   (port_in),
        .cursor    (cursor)
    );

    // ########################################
    // helpers
    // ########################################

    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]}; // x^32+x^22+x^2+x+1.
    endfunction

    task automatic take_bits(input int count, output logic [31:0] bits);
        bits = '0;
        for (int i = 0; i < count; i++) begin
            bits = {bits[30:0], lfsr[31]};    // one lfsr step per bit.
            lfsr = lfsr_next(lfsr);
        end
    endtask

    task automatic next_cycles(input int count);
        repeat (count) @(posedge clock50);
        #1;                                    // inputs move just after the edge.
    endtask

    task automatic check_value(input string name, input logic [15:0] expected,
                               input logic [15:0] actual);
        assert (actual == expected) else begin
            $display("mismatch %s: expected %h actual %h", name, expected, actual);
            $display("Regression failed");
            $fatal(1, "value check did not hold");
        end
    endtask

    // start, data lsb first, parity, stop; each clock half is 10 cycles.
    task automatic send_frame(input logic [7:0] code, input logic bad_parity);
        logic [10:0] frame;
        frame = {1'b1, ~^code ^ bad_parity, code, 1'b0};
        for (int i = 0; i < 11; i++) begin
            ps2_dat = frame[i];
            next_cycles(10);
            ps2_clk = 1'b0;                    // receiver samples on this fall.
            next_cycles(10);
            ps2_clk = 1'b1;
        end
        ps2_dat = 1'b1;
        next_cycles(20);
    endtask

    // value is port_in while the strobe is high and thus the previous read's latch.
    task automatic read_port(input logic [15:0] addr, output logic [15:0] value);
        port_addr = addr;
        port_read = 1'b1;
        next_cycles(3);
        value     = port_in;
        port_read = 1'b0;
        next_cycles(3);
    endtask

    task automatic write_port(input logic [15:0] addr, input logic [15:0] data);
        port_addr = addr;
        port_out  = data;
        port_clk  = 1'b1;
        next_cycles(3);
        port_clk  = 1'b0;                      // write lands on this fall.
        next_cycles(3);
    endtask

    task automatic wait_ready(input string name);
        logic [15:0] value;
        logic        found;
        found = 1'b0;
        value = '0;
        for (int i = 0; i < 500 && !found; i++) begin
            read_port(port_kbd_status, value);
            found = value[0];
        end
        if (!found) begin
            $display("Regression failed");
            $fatal(1, "%s: keyboard status never showed a byte after 500 reads", name);
        end
        check_value(name, 16'h0001, value);
    endtask

    task automatic expect_idle(input string name);
        logic [15:0] value;
        read_port(port_kbd_status, value);
        read_port(port_kbd_status, value);     // second one shows the first's status.
        check_value(name, 16'h0000, value);
    endtask

    task automatic read_key(input string name, input logic [7:0] expected);
        logic [15:0] value;
        read_port(port_kbd_data, value);
        read_port(port_kbd_data, value);
        check_value(name, {8'h00, expected}, value);
        expect_idle({name, " idle"});
    endtask

    task automatic write_cursor(input logic [10:0] position);
        write_port(port_crtc_index, {12'h000, crtc_cursor_hi});
        write_port(port_crtc_data, {13'h0000, position[10:8]});
        write_port(port_crtc_index, {12'h000, crtc_cursor_lo});
        write_port(port_crtc_data, {8'h00, position[7:0]});
    endtask

    // ########################################
    // test sequence
    // ########################################

    initial begin
        logic [31:0] bits;
        logic [15:0] value;
        logic [10:0] position;
        int          j;
        int          tmp;
        int          k;
        at_codes[0] = 8'h1C;
        xt_codes[0] = 8'h1E;
        at_codes[1] = 8'h16;
        xt_codes[1] = 8'h02;
        at_codes[2] = 8'h5A;
        xt_codes[2] = 8'h1C;
        at_codes[3] = 8'h76;
        xt_codes[3] = 8'h01;
        at_codes[4] = 8'h05;
        xt_codes[4] = 8'h3B;
        at_codes[5] = 8'hE0;
        xt_codes[5] = 8'hE0;                   // extended prefix passes through.
        arst_n    = 1'b0;
        port_addr = '0;
        port_out  = '0;
        port_clk  = 1'b0;
        port_read = 1'b0;
        ps2_clk   = 1'b1;                      // ps2 bus idles high.
        ps2_dat   = 1'b1;
        next_cycles(2);
        arst_n = 1'b1;
        next_cycles(2);

        check_value("reset cursor", 16'h0000, 16'(cursor));
        expect_idle("reset status");
        read_port(16'h03F8, value);            // nothing decodes here.
        read_port(16'h03F8, value);
        check_value("unmapped port", 16'h0000, value);

        for (int i = 0; i < 6; i++) begin
            order[i] = i;
        end
        for (int i = 5; i > 0; i--) begin
            take_bits(3, bits);
            j        = int'(bits[2:0]) % (i + 1);
            tmp      = order[i];
            order[i] = order[j];
            order[j] = tmp;
        end

        for (int i = 0; i < 6; i++) begin      // make codes.
            k = order[i];
            send_frame(at_codes[k], 1'b0);
            wait_ready($sformatf("make %h ready", at_codes[k]));
            read_key($sformatf("make %h", at_codes[k]), xt_codes[k]);
        end

        send_frame(at_break_prefix, 1'b0);     // prefix alone delivers nothing.
        expect_idle("break prefix alone");
        k = order[0];
        send_frame(at_codes[k], 1'b0);
        wait_ready("break after lone prefix ready");
        read_key("break after lone prefix", xt_codes[k] | 8'h80);
        for (int i = 5; i >= 0; i--) begin     // break codes.
            k = order[i];
            send_frame(at_break_prefix, 1'b0);
            send_frame(at_codes[k], 1'b0);
            wait_ready($sformatf("break %h ready", at_codes[k]));
            read_key($sformatf("break %h", at_codes[k]), xt_codes[k] | 8'h80);
        end

        send_frame(at_codes[1], 1'b1);         // bad parity.
        expect_idle("parity error first");
        expect_idle("parity error second");
        send_frame(at_codes[2], 1'b0);
        wait_ready("after parity error ready");
        read_key("after parity error", xt_codes[2]);

        take_bits(3, bits);                    // overrun where the last byte wins.
        k = int'(bits[2:0]) % 6;
        send_frame(at_codes[(k + 1) % 6], 1'b0);
        send_frame(at_codes[k], 1'b0);
        wait_ready("overrun ready");
        read_key("overrun", xt_codes[k]);

        for (int i = 0; i < 8; i++) begin      // cursor position.
            take_bits(11, bits);
            position = bits[10:0];
            write_cursor(position);
            check_value("cursor write", {5'h00, position}, 16'(cursor));
        end
        write_port(port_crtc_index, 16'h0003); // register not held here.
        // data differs from both cursor halves.
        write_port(port_crtc_data, {8'h00, ~position[7:3], ~position[10:8]});
        check_value("cursor other index", {5'h00, position}, 16'(cursor));

        $display("Regression passed");
        $finish;
    end

endmodule

// ==== all.f ====
rtl/pc_io_pkg.sv
rtl/ps2_receiver.sv
rtl/scancode_xlat.sv
rtl/keyboard_port.sv
rtl/crtc_regs.sv
rtl/port_controller.sv
testbench/tb_port_controller.sv

// ==== run.sh ====
#!/bin/sh
# compile with verilator and run; the exit status is the regression result.
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal --top-module tb_port_controller -f all.f &&
./obj_dir/Vtb_port_controller || exit 1
